/* include/psram_defines.svh */
`ifndef PSRAM_DEFINES_SVH
`define PSRAM_DEFINES_SVH

// Bus geometry
`define PSRAM_AW        10
`define PSRAM_DW        16
`define PSRAM_DEPTH     1024

// Legal latency codes, in clocks from the address cycle to the first beat
`define PSRAM_LAT_MIN   3
`define PSRAM_LAT_MAX   6
`define PSRAM_LAT_RST   4

`define PSRAM_BURST_MAX 8   // Longest burst, also the write buffer depth

`endif

/* hw/psram_bus_pkg.sv */
`default_nettype none

`include "psram_defines.svh"

package psram_bus_pkg;

    // Device side sequencing in the memory model
    typedef enum logic [1:0] {
        dev_idle,   // Waiting for an address cycle
        dev_wait,   // Counting initial latency, wait_o high
        dev_data    // Burst beats
    } psram_dev_state_t;

    // Bus configuration word, sent on addr with cre high
    typedef struct packed {
        logic [`PSRAM_AW-5:0] rsvd;     // Must be zero
        logic                 burst8;   // 0 = 4 words, 1 = 8 words
        logic [2:0]           latency;  // Latency code
    } psram_bcr_t;

endpackage

`default_nettype wire

/* hw/psram_host_pkg.sv */
`default_nettype none

package psram_host_pkg;

    // Host request codes
    typedef enum logic [1:0] {
        op_read   = 2'b00,
        op_write  = 2'b01,
        op_config = 2'b10
    } psram_op_t;

    // Controller FSM
    typedef enum logic [2:0] {
        st_idle,    // Ready for a request
        st_fill,    // Collecting write data into the buffer
        st_addr,    // Address cycle on the bus
        st_wait,    // Initial latency
        st_data,    // Burst beats
        st_cfg      // Gap while the register block settles
    } psram_ctrl_state_t;

endpackage

`default_nettype wire

/* hw/psram_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "psram_defines.svh"

interface psram_bus_if;

    logic [`PSRAM_AW-1:0] addr;
    logic                 adv_n;
    logic                 ce_n;
    logic                 oe_n;
    logic                 we_n;
    logic                 cre;      // Configuration register access
    logic                 wait_o;   // Device still in initial latency
    logic [`PSRAM_DW-1:0] wdata;
    logic [`PSRAM_DW-1:0] rdata;

    modport ctrl (output addr, adv_n, ce_n, oe_n, we_n, cre, wdata,
                  input  wait_o, rdata);

    modport mem (input  addr, adv_n, ce_n, oe_n, we_n, cre, wdata,
                 output wait_o, rdata);

endinterface

`default_nettype wire

/* hw/psram_cfg_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "psram_defines.svh"

module psram_cfg_regs import psram_bus_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cfg_load,
    input  psram_bcr_t cfg_word,
    output logic [2:0] cfg_latency,
    output logic       cfg_burst8
);

    logic lat_ok;

    // Out of range codes would give a wait phase the device cannot honour
    assign lat_ok = (cfg_word.latency >= 3'(`PSRAM_LAT_MIN)) &&
                    (cfg_word.latency <= 3'(`PSRAM_LAT_MAX));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_latency <= 3'(`PSRAM_LAT_RST);
            cfg_burst8  <= 1'b0;             // 4 word bursts
        end else if (cfg_load) begin
            if (lat_ok) begin
                cfg_latency <= cfg_word.latency;
            end
            cfg_burst8 <= cfg_word.burst8;   // Either length is legal
        end
    end

endmodule

`default_nettype wire

/* hw/psram_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "psram_defines.svh"

module psram_ctrl import psram_bus_pkg::*, psram_host_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  psram_op_t            req_op,
    input  logic [`PSRAM_AW-1:0] req_addr,
    input  logic                 wr_valid,
    output logic                 wr_ready,
    input  logic [`PSRAM_DW-1:0] wr_data,
    output logic                 rd_valid,
    output logic [`PSRAM_DW-1:0] rd_data,
    output logic                 rd_last,
    input  logic [2:0]           cfg_latency,
    input  logic                 cfg_burst8,
    output logic                 cfg_load,
    output psram_bcr_t           cfg_word,
    psram_bus_if.ctrl            bus
);

    localparam int BW = $clog2(`PSRAM_BURST_MAX);

    psram_ctrl_state_t    state, state_nx;
    psram_op_t            op_q;
    logic [`PSRAM_AW-1:0] addr_q;
    logic [`PSRAM_DW-1:0] wbuf [`PSRAM_BURST_MAX];
    logic [BW-1:0]        beat_cnt;   // Fill index, then bus beat index
    logic [2:0]           lat_cnt;
    logic                 req_fire, wr_fire, beat_last, lat_done, rd_beat, cfg_cycle;
    psram_bcr_t           cfg_bcr;

    assign req_fire  = req_valid && req_ready;
    assign wr_fire   = wr_valid && wr_ready;
    assign beat_last = beat_cnt == (cfg_burst8 ? BW'(`PSRAM_BURST_MAX - 1)
                                               : BW'(`PSRAM_BURST_MAX / 2 - 1));
    assign lat_done  = lat_cnt == 3'd0;
    assign rd_beat   = (state == st_data) && (op_q == op_read) && !bus.wait_o;
    assign cfg_cycle = (state == st_addr) && (op_q == op_config);

    // Register block takes the raw word, the device gets what was kept
    assign cfg_load = req_fire && (req_op == op_config);
    assign cfg_word = psram_bcr_t'(req_addr);
    assign cfg_bcr  = '{rsvd: '0, burst8: cfg_burst8, latency: cfg_latency};

    always_comb begin
        state_nx = state;
        case (state)
            st_idle: if (req_fire) begin
                case (req_op)
                    op_read:   state_nx = st_addr;
                    op_write:  state_nx = st_fill;
                    op_config: state_nx = st_cfg;
                    default:   state_nx = st_idle;
                endcase
            end
            st_fill: if (wr_fire && beat_last) state_nx = st_addr;
            st_cfg:  state_nx = st_addr;
            st_addr: state_nx = (op_q == op_config) ? st_idle : st_wait;
            st_wait: if (lat_done) state_nx = st_data;
            st_data: if (beat_last) state_nx = st_idle;
            default: state_nx = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            op_q      <= op_read;
            beat_cnt  <= '0;
            lat_cnt   <= '0;
            req_ready <= 1'b0;
            wr_ready  <= 1'b0;
            rd_valid  <= 1'b0;
            rd_last   <= 1'b0;
        end else begin
            state     <= state_nx;
            req_ready <= state_nx == st_idle;   // Tracks the state, no lag
            wr_ready  <= state_nx == st_fill;
            rd_valid  <= rd_beat;
            rd_last   <= rd_beat && beat_last;
            if (req_fire) op_q <= req_op;

            // Wait phase lasts latency minus one cycles
            if (state == st_addr) begin
                lat_cnt <= cfg_latency - 3'd2;
            end else if (state == st_wait && !lat_done) begin
                lat_cnt <= lat_cnt - 3'd1;
            end

            if (req_fire || state == st_wait) begin
                beat_cnt <= '0;
            end else if (wr_fire || state == st_data) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) addr_q <= req_addr;
        if (wr_fire) wbuf[beat_cnt] <= wr_data;
        if (rd_beat) rd_data <= bus.rdata;
    end

    // Bus strobes decode straight from the state
    assign bus.ce_n  = !(state inside {st_addr, st_wait, st_data});
    assign bus.adv_n = state != st_addr;
    assign bus.we_n  = !((state == st_addr) && (op_q != op_read));
    assign bus.oe_n  = !((op_q == op_read) && (state inside {st_wait, st_data}));
    assign bus.cre   = cfg_cycle;
    assign bus.addr  = cfg_cycle ? cfg_bcr : addr_q;
    assign bus.wdata = wbuf[beat_cnt];

endmodule

`default_nettype wire

/* hw/psram_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "psram_defines.svh"

module psram_model import psram_bus_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    psram_bus_if.mem bus
);

    localparam int BW = $clog2(`PSRAM_BURST_MAX);

    psram_dev_state_t     state;
    logic [`PSRAM_DW-1:0] mem [`PSRAM_DEPTH];
    logic [`PSRAM_AW-1:0] addr_q;     // Internal burst address
    logic [2:0]           lat_q;      // Device copy of the latency code
    logic                 burst8_q;
    logic                 is_write;
    logic [2:0]           wait_cnt;
    logic [BW-1:0]        beat_cnt;
    logic                 addr_start, beat_last;
    psram_bcr_t           bcr;

    assign addr_start = !bus.ce_n && !bus.adv_n;
    assign bcr        = psram_bcr_t'(bus.addr);
    assign beat_last  = beat_cnt == (burst8_q ? BW'(`PSRAM_BURST_MAX - 1)
                                              : BW'(`PSRAM_BURST_MAX / 2 - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= dev_idle;
            lat_q    <= 3'(`PSRAM_LAT_RST);
            burst8_q <= 1'b0;
            is_write <= 1'b0;
            wait_cnt <= '0;
            beat_cnt <= '0;
        end else begin
            case (state)
                dev_idle: if (addr_start) begin
                    if (bus.cre) begin
                        lat_q    <= bcr.latency;    // Register write, no data phase
                        burst8_q <= bcr.burst8;
                    end else begin
                        state    <= dev_wait;
                        is_write <= !bus.we_n;
                        wait_cnt <= lat_q - 3'd2;
                    end
                end
                dev_wait: begin
                    if (wait_cnt == 3'd0) begin
                        state    <= dev_data;
                        beat_cnt <= '0;
                    end else begin
                        wait_cnt <= wait_cnt - 3'd1;
                    end
                end
                dev_data: begin
                    beat_cnt <= beat_cnt + 1'b1;
                    if (beat_last || bus.ce_n) state <= dev_idle;   // ce_n high ends early
                end
                default: state <= dev_idle;
            endcase
        end
    end

    // Array and burst address
    always_ff @(posedge clk) begin
        if (state == dev_idle && addr_start) begin
            addr_q <= bus.addr;
        end else if (state == dev_data) begin
            if (is_write) mem[addr_q] <= bus.wdata;
            addr_q <= (addr_q == `PSRAM_AW'(`PSRAM_DEPTH - 1)) ? '0 : addr_q + 1'b1;
        end
    end

    assign bus.wait_o = state == dev_wait;
    assign bus.rdata  = (state == dev_data && !is_write && !bus.oe_n) ? mem[addr_q] : '0;

endmodule

`default_nettype wire

/* hw/psram_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "psram_defines.svh"

module psram_subsystem import psram_bus_pkg::*, psram_host_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  psram_op_t            req_op,
    input  logic [`PSRAM_AW-1:0] req_addr,
    input  logic                 wr_valid,
    output logic                 wr_ready,
    input  logic [`PSRAM_DW-1:0] wr_data,
    output logic                 rd_valid,
    output logic [`PSRAM_DW-1:0] rd_data,
    output logic                 rd_last,
    output logic [2:0]           cur_latency,   // Latency the controller runs with
    output logic                 cur_burst8
);

    logic       cfg_load;
    psram_bcr_t cfg_word;

    psram_bus_if bus ();

    psram_cfg_regs u_cfg_regs (
        .clk, .rst_n, .cfg_load, .cfg_word,
        .cfg_latency (cur_latency),
        .cfg_burst8  (cur_burst8)
    );

    psram_ctrl u_ctrl (
        .clk, .rst_n,
        .req_valid, .req_ready, .req_op, .req_addr,
        .wr_valid, .wr_ready, .wr_data,
        .rd_valid, .rd_data, .rd_last,
        .cfg_latency (cur_latency),
        .cfg_burst8  (cur_burst8),
        .cfg_load, .cfg_word,
        .bus         (bus.ctrl)
    );

    psram_model u_model (.clk, .rst_n, .bus(bus.mem));

endmodule

`default_nettype wire

/* test/psram_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module psram_chk import psram_host_pkg::*; (
    input wire logic              clk,
    input wire logic              rst_n,
    input wire psram_ctrl_state_t state,
    input wire logic              req_ready,
    input wire logic              rd_valid,
    input wire logic              ce_n,
    input wire logic              oe_n,
    input wire logic              cre,
    input wire logic              wait_o
);

    // Output enable only inside a chip select window
    a_oe_in_ce: assert property (@(posedge clk) disable iff (!rst_n) !oe_n |-> !ce_n)
        else $error("oe_n low while ce_n is high");

    a_rd_no_wait: assert property (@(posedge clk) disable iff (!rst_n) rd_valid |-> !wait_o)
        else $error("rd_valid high during wait_o");

    a_ready_idle: assert property (@(posedge clk) disable iff (!rst_n)
                                   (state != st_idle) |-> !req_ready)
        else $error("req_ready high outside the idle state");

    // Register access has no data phase
    a_cre_no_data: assert property (@(posedge clk) disable iff (!rst_n)
                                    cre |-> (state != st_data))
        else $error("cre high during a data beat");

endmodule

bind psram_ctrl psram_chk u_chk (
    .clk, .rst_n, .state, .req_ready, .rd_valid,
    .ce_n (bus.ce_n), .oe_n (bus.oe_n), .cre (bus.cre), .wait_o (bus.wait_o)
);

`default_nettype wire

/* test/tb_psram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "psram_defines.svh"

module tb_psram import psram_host_pkg::*;;

    logic                 clk = 1'b0;
    logic                 rst_n, req_valid, req_ready, wr_valid, wr_ready;
    logic                 rd_valid, rd_last, cur_burst8;
    psram_op_t            req_op;
    logic [`PSRAM_AW-1:0] req_addr;
    logic [`PSRAM_DW-1:0] wr_data, rd_data;
    logic [2:0]           cur_latency;

    int                   errors = 0;
    int                   checks = 0;
    int                   cycles = 0;
    logic [31:0]          rng;
    logic [`PSRAM_DW-1:0] ref_mem [`PSRAM_DEPTH];
    logic                 ref_ok [`PSRAM_DEPTH];   // Word has been written
    int                   ref_lat;
    logic                 ref_b8;

    psram_subsystem dut_i (.*);

    always #4 clk = !clk;

    // Run limit, 300 operations of up to about 30 cycles
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 12000) begin
            $display("Timeout, the run did not finish within 12000 cycles");
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    // Returns right after the accepting edge
    task automatic send_req(input psram_op_t op, input logic [`PSRAM_AW-1:0] addr);
        @(posedge clk);
        req_valid <= 1'b1;
        req_op    <= op;
        req_addr  <= addr;
        do @(negedge clk); while (!req_ready);
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    task automatic do_write(input logic [`PSRAM_AW-1:0] addr);
        logic [`PSRAM_DW-1:0] d [8];
        int blen;
        int i;
        blen = ref_b8 ? 8 : 4;
        for (i = 0; i < blen; i++) begin
            rng = xorshift(rng);
            d[i] = rng[15:0];
        end
        send_req(op_write, addr);
        i = 0;
        while (i < blen) begin
            @(posedge clk);
            rng = xorshift(rng);
            wr_valid <= rng[1:0] != 2'b00;   // Gaps give back-pressure
            wr_data  <= d[i];
            @(negedge clk);
            if (wr_valid && wr_ready) i++;
        end
        @(posedge clk);
        wr_valid <= 1'b0;
        for (i = 0; i < blen; i++) begin
            ref_mem[(addr + i) % `PSRAM_DEPTH] = d[i];
            ref_ok[(addr + i) % `PSRAM_DEPTH]  = 1'b1;
        end
        do @(negedge clk); while (!req_ready);
    endtask

    task automatic do_read(input logic [`PSRAM_AW-1:0] addr, input string name);
        int blen;
        int k;
        int beats;
        int a;
        blen  = ref_b8 ? 8 : 4;
        k     = 0;
        beats = 0;
        send_req(op_read, addr);
        do begin
            @(negedge clk);
            k++;
            if (rd_valid) begin
                a = (addr + beats) % `PSRAM_DEPTH;
                if (beats == 0) check_val({name, " first beat delay"}, 2 + ref_lat, k);
                if (ref_ok[a]) check_val({name, " data"}, ref_mem[a], rd_data);
                check_val({name, " rd_last"}, beats == blen - 1, rd_last);
                beats++;
            end
        end while (!req_ready && k < 100);
        check_val({name, " beat count"}, blen, beats);
    endtask

    task automatic do_config(input logic [2:0] lat, input logic b8, input string name);
        send_req(op_config, {6'b0, b8, lat});
        if (lat >= `PSRAM_LAT_MIN && lat <= `PSRAM_LAT_MAX) ref_lat = lat;
        ref_b8 = b8;
        @(negedge clk);
        check_val({name, " cur_latency"}, ref_lat, cur_latency);
        check_val({name, " cur_burst8"}, ref_b8, cur_burst8);
        do @(negedge clk); while (!req_ready);
    endtask

    task automatic random_op(input string name);
        logic [`PSRAM_AW-1:0] addr;
        rng = xorshift(rng);
        // One in eight lands near the top so bursts wrap
        addr = (rng[2:0] == 3'd0) ? `PSRAM_AW'(`PSRAM_DEPTH - 1 - rng[5:3]) : rng[17:8];
        if (rng[31]) do_write(addr);
        else do_read(addr, name);
    endtask

    initial begin
        req_valid = 1'b0;
        req_op    = op_read;
        req_addr  = '0;
        wr_valid  = 1'b0;
        wr_data   = '0;
        rst_n     = 1'b0;
        rng       = 32'd91;
        ref_lat   = `PSRAM_LAT_RST;
        ref_b8    = 1'b0;
        for (int i = 0; i < `PSRAM_DEPTH; i++) ref_ok[i] = 1'b0;

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_val("reset req_ready", 0, req_ready);
        check_val("reset rd_valid", 0, rd_valid);
        check_val("reset wr_ready", 0, wr_ready);
        check_val("reset cur_latency", 4, cur_latency);
        check_val("reset cur_burst8", 0, cur_burst8);
        @(negedge clk);
        if (!req_ready) begin
            errors++;
            $display("req_ready did not rise after reset was released");
        end

        do_write('0);
        do_read('0, "directed");

        repeat (250) random_op("random");

        repeat (6) begin
            rng = xorshift(rng);
            do_config(3'(`PSRAM_LAT_MIN + rng[9:8]), rng[12], "legal config");
            repeat (6) random_op("after legal config");
        end

        for (int i = 0; i < 4; i++) begin
            rng = xorshift(rng);
            do_config((i == 3) ? 3'd7 : 3'(i), rng[4], "illegal config");
            repeat (3) random_op("after illegal config");
        end

        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+include
hw/psram_bus_pkg.sv
hw/psram_host_pkg.sv
hw/psram_bus_if.sv
hw/psram_cfg_regs.sv
hw/psram_ctrl.sv
hw/psram_model.sv
hw/psram_subsystem.sv
test/psram_chk.sv
test/tb_psram.sv

/* run.sh */
#!/bin/sh
# Build and run the psram testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f src.f --top-module tb_psram
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_psram)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF '** PASS **'; then
    exit 0
fi
exit 1
